//--- src.f
verilog/periph_pkg.sv
verilog/periph_reg_rw.sv
verilog/periph_gpio.sv
verilog/periph_timer.sv
verilog/periph_irq_ctrl.sv
verilog/periph_subsys.sv
sim/periph_assert.sv
sim/periph_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the peripheral subsystem testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module periph_tb \
    -o periph_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/periph_sim +verilator+error+limit+1000 > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "Test failed" sim.log && { echo "FAILED"; exit 1; }
grep -q "Test passed" sim.log || { echo "FAILED"; exit 1; }
echo "PASSED"

//--- sim/periph_tb.sv
/*
 * Testbench for the peripheral subsystem. Drives the system bus and the
 * GPIO inputs through reset, readback, interrupt, timer and decode tests.
 */
module periph_tb
    import periph_pkg::*;
();

    localparam int CMP_VALUE = 20;

    logic     clk;
    logic     reset;
    bus_req_t bus_req;
    byte_t    rdata;
    pins_t    gpi;
    pins_t    gpo;
    logic     irq;
    int       seed = 32'hb8b1c8e0;
    int       errors = 0;
    int       tests_failed = 0;
    int       cycle = 0;

    periph_subsys periph_subsys_inst (
        .clk     (clk),
        .reset   (reset),
        .bus_req (bus_req),
        .rdata   (rdata),
        .gpi     (gpi),
        .gpo     (gpo),
        .irq     (irq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_equal(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        assert (got == expected) else begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, expected);
        end
    endtask

    task automatic bus_write(input addr_t addr, input byte_t data);
        @(posedge clk);
        bus_req <= '{enable: 1'b1, write_en: 1'b1, addr: addr, data: data};
        @(posedge clk);
        bus_req <= '0;
    endtask

    task automatic write_without_enable(input addr_t addr, input byte_t data);
        @(posedge clk);
        bus_req <= '{enable: 1'b0, write_en: 1'b1, addr: addr, data: data};
        @(posedge clk);
        bus_req <= '0;
    endtask

    // read data is combinational, so it is taken in the middle of the cycle.
    task automatic bus_read(input addr_t addr, output byte_t data);
        @(posedge clk);
        bus_req <= '{enable: 1'b1, write_en: 1'b0, addr: addr, data: 8'h00};
        @(negedge clk);
        data = rdata;
        @(posedge clk);
        bus_req <= '0;
    endtask

    task automatic read_check(input string name, input addr_t addr, input byte_t expected);
        byte_t got;
        bus_read(addr, got);
        check_equal(name, 16'(got), 16'(expected));
    endtask

    task automatic wait_irq(input logic level, input int limit, output int at_cycle);
        int n;
        n = 0;
        @(negedge clk);
        while (irq !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        at_cycle = cycle;
        if (irq !== level) begin
            errors++;
            $display("Timeout while waiting for irq to become %0b", level);
        end
    endtask

    task automatic report(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int    start;
        int    t0;
        int    t1;
        int    t2;
        int    assert_fails;
        byte_t lo;
        byte_t hi;
        byte_t r;
        byte_t written [8];
        pins_t last_gpo;

        reset   = 1'b0;
        bus_req = '0;
        gpi     = pins_t'($random(seed));
        repeat (2) @(posedge clk);
        reset <= 1'b1;

        start = errors;
        @(negedge clk);
        check_equal("gpo", gpo, 16'h0000);
        check_equal("irq", 16'(irq), 16'h0000);
        for (int i = 0; i < 8; i++) begin
            read_check("gpio rdata", GPIO_BASE_DEFAULT + addr_t'(i),
                       (i == GPI_LO) ? gpi[7:0] : (i == GPI_HI) ? gpi[15:8] : 8'h00);
        end
        for (int i = 0; i < 5; i++) begin
            read_check("timer rdata", TIMER_BASE_DEFAULT + addr_t'(i), 8'h00);
        end
        for (int i = 0; i < 2; i++) begin
            read_check("irq rdata", IRQ_BASE_DEFAULT + addr_t'(i), 8'h00);
        end
        report("reset", start);

        start = errors;
        for (int i = 0; i < 8; i++) begin
            if (i != GPI_LO && i != GPI_HI) begin
                r = byte_t'($random(seed));
                written[i] = r;
                bus_write(GPIO_BASE_DEFAULT + addr_t'(i), r);
                read_check("gpio register", GPIO_BASE_DEFAULT + addr_t'(i), r);
            end
        end
        @(negedge clk);
        check_equal("gpo", gpo, {written[GPO_HI], written[GPO_LO]});
        @(posedge clk);
        gpi <= pins_t'($random(seed));
        @(negedge clk);
        read_check("gpi lo", GPIO_BASE_DEFAULT + GPI_LO, gpi[7:0]);
        read_check("gpi hi", GPIO_BASE_DEFAULT + GPI_HI, gpi[15:8]);
        report("register readback", start);

        start = errors;
        for (int i = RISE_LO; i <= FALL_HI; i++) begin
            bus_write(GPIO_BASE_DEFAULT + addr_t'(i), 8'h00);
        end
        @(posedge clk);
        gpi <= '0;
        repeat (4) @(posedge clk);
        bus_write(IRQ_BASE_DEFAULT + PENDING, 8'h03);
        bus_write(GPIO_BASE_DEFAULT + RISE_LO, 8'h01);
        bus_write(GPIO_BASE_DEFAULT + FALL_LO, 8'h02);
        bus_write(IRQ_BASE_DEFAULT + MASK, 8'(1 << IRQ_GPIO));
        @(posedge clk);
        gpi <= 16'h0001;
        wait_irq(1'b1, 10, t0);
        read_check("pending", IRQ_BASE_DEFAULT + PENDING, 8'h01);
        bus_write(IRQ_BASE_DEFAULT + PENDING, 8'h01);
        wait_irq(1'b0, 5, t0);
        read_check("pending", IRQ_BASE_DEFAULT + PENDING, 8'h00);
        // pin 1 only has a fall mask, so its rising edge is ignored.
        @(posedge clk);
        gpi <= 16'h0003;
        repeat (6) @(posedge clk);
        read_check("pending", IRQ_BASE_DEFAULT + PENDING, 8'h00);
        @(negedge clk);
        check_equal("irq", 16'(irq), 16'h0000);
        report("gpio interrupts", start);

        start = errors;
        bus_write(IRQ_BASE_DEFAULT + MASK, 8'(1 << IRQ_TIMER));
        bus_write(TIMER_BASE_DEFAULT + CMP_LO, 8'(CMP_VALUE));
        bus_write(TIMER_BASE_DEFAULT + CMP_HI, 8'h00);
        bus_write(IRQ_BASE_DEFAULT + PENDING, 8'h03);
        bus_write(TIMER_BASE_DEFAULT + CTRL, 8'h01);
        wait_irq(1'b1, 4 * CMP_VALUE, t0);
        bus_write(IRQ_BASE_DEFAULT + PENDING, 8'h02);
        wait_irq(1'b0, 5, t1);
        wait_irq(1'b1, 4 * CMP_VALUE, t1);
        bus_write(IRQ_BASE_DEFAULT + PENDING, 8'h02);
        wait_irq(1'b0, 5, t2);
        wait_irq(1'b1, 4 * CMP_VALUE, t2);
        check_equal("tick interval", 16'(t1 - t0), 16'(CMP_VALUE + 1));
        check_equal("tick interval", 16'(t2 - t1), 16'(CMP_VALUE + 1));
        for (int i = 0; i < 6; i++) begin
            bus_read(TIMER_BASE_DEFAULT + CNT_LO, lo);
            bus_read(TIMER_BASE_DEFAULT + CNT_HI, hi);
            assert ({hi, lo} <= 16'(CMP_VALUE)) else begin
                errors++;
                $display("Fail count: 0x%h is above compare 0x%h", {hi, lo}, 16'(CMP_VALUE));
            end
        end
        bus_write(TIMER_BASE_DEFAULT + CTRL, 8'h00);
        report("timer", start);

        start = errors;
        last_gpo = {written[GPO_HI], written[GPO_LO]};
        bus_write(GPIO_BASE_DEFAULT - 16'd1, 8'hFF);
        bus_write(TIMER_BASE_DEFAULT + TIMER_SPAN, 8'hFF);
        bus_write(IRQ_BASE_DEFAULT + IRQ_SPAN, 8'hFF);
        write_without_enable(GPIO_BASE_DEFAULT + GPO_LO, ~last_gpo[7:0]);
        write_without_enable(IRQ_BASE_DEFAULT + MASK, 8'hFF);
        read_check("rdata", GPIO_BASE_DEFAULT - 16'd1, 8'h00);
        read_check("rdata", TIMER_BASE_DEFAULT + TIMER_SPAN, 8'h00);
        read_check("rdata", IRQ_BASE_DEFAULT + IRQ_SPAN, 8'h00);
        @(negedge clk);
        check_equal("gpo", gpo, last_gpo);
        read_check("fall hi", GPIO_BASE_DEFAULT + FALL_HI, 8'h00);
        read_check("ctrl", TIMER_BASE_DEFAULT + CTRL, 8'h00);
        read_check("cmp lo", TIMER_BASE_DEFAULT + CMP_LO, 8'(CMP_VALUE));
        read_check("mask", IRQ_BASE_DEFAULT + MASK, 8'(1 << IRQ_TIMER));
        report("address decoding", start);

        assert_fails = periph_subsys_inst.assert_inst.fail_count;
        $display("tests run 5, tests failed %0d, check errors %0d, assertion failures %0d",
                 tests_failed, errors, assert_fails);
        if (tests_failed == 0 && errors == 0 && assert_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- sim/periph_assert.sv
/*
 * Concurrent assertions on the peripheral subsystem, bound to its top level.
 */
module periph_assert
    import periph_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input bus_req_t bus_req,
    input byte_t    rdata,
    input pins_t    gpo,
    input logic     irq,
    input irq_vec_t pending,
    input byte_t    mask,
    input logic     timer_tick,
    input count_t   count,
    input count_t   cmp
);

    int    fail_count = 0;
    pins_t gpo_model;
    logic  in_window;

    always_ff @(posedge clk) begin
        if (!reset) begin
            gpo_model <= '0;
        end else if (bus_req.enable && bus_req.write_en) begin
            if (bus_req.addr == GPIO_BASE_DEFAULT + GPO_LO) begin
                gpo_model[7:0] <= bus_req.data;
            end else if (bus_req.addr == GPIO_BASE_DEFAULT + GPO_HI) begin
                gpo_model[15:8] <= bus_req.data;
            end
        end
    end

    assign in_window = bus_req.enable && (
        (bus_req.addr >= GPIO_BASE_DEFAULT && bus_req.addr < GPIO_BASE_DEFAULT + GPIO_SPAN) ||
        (bus_req.addr >= TIMER_BASE_DEFAULT && bus_req.addr < TIMER_BASE_DEFAULT + TIMER_SPAN) ||
        (bus_req.addr >= IRQ_BASE_DEFAULT && bus_req.addr < IRQ_BASE_DEFAULT + IRQ_SPAN));

    irq_needs_masked_pending: assert property (@(posedge clk) disable iff (!reset)
        !$past(|(pending & mask[1:0])) |-> !irq)
        else begin
            fail_count++;
            $error("irq is high although no unmasked pending bit was set");
        end

    rdata_zero_outside: assert property (@(posedge clk) disable iff (!reset)
        !in_window |-> rdata == '0)
        else begin
            fail_count++;
            $error("rdata is not zero outside every window");
        end

    gpo_follows_writes: assert property (@(posedge clk) disable iff (!reset)
        gpo == gpo_model)
        else begin
            fail_count++;
            $error("gpo differs from the bytes written to GPO_LO and GPO_HI");
        end

    tick_on_compare: assert property (@(posedge clk) disable iff (!reset)
        timer_tick |-> $past(count == cmp))
        else begin
            fail_count++;
            $error("timer_tick without the count at the compare value");
        end

endmodule

bind periph_subsys periph_assert assert_inst (
    .clk        (clk),
    .reset      (reset),
    .bus_req    (bus_req),
    .rdata      (rdata),
    .gpo        (gpo),
    .irq        (irq),
    .pending    (irq_inst.pending),
    .mask       (irq_inst.mask),
    .timer_tick (timer_tick),
    .count      (timer_inst.count),
    .cmp        (timer_inst.cmp)
);

//--- verilog/periph_subsys.sv
/*
 * Peripheral subsystem top level. Places the GPIO block, the interval timer
 * and the interrupt controller on the system bus and merges their read data.
 */
module periph_subsys
    import periph_pkg::*;
#(
    parameter addr_t gpio_base  = GPIO_BASE_DEFAULT,
    parameter addr_t timer_base = TIMER_BASE_DEFAULT,
    parameter addr_t irq_base   = IRQ_BASE_DEFAULT
) (
    input  logic     clk,
    input  logic     reset,
    input  bus_req_t bus_req,
    output byte_t    rdata,
    input  pins_t    gpi,
    output pins_t    gpo,
    output logic     irq
);

    byte_t    gpio_rdata;
    byte_t    timer_rdata;
    byte_t    irq_rdata;
    logic     gpio_event;
    logic     timer_tick;
    irq_vec_t events;

    periph_gpio #(.base_addr(gpio_base)) gpio_inst (
        .clk        (clk),
        .reset      (reset),
        .bus_req    (bus_req),
        .rdata      (gpio_rdata),
        .gpi        (gpi),
        .gpo        (gpo),
        .gpio_event (gpio_event)
    );

    periph_timer #(.base_addr(timer_base)) timer_inst (
        .clk        (clk),
        .reset      (reset),
        .bus_req    (bus_req),
        .rdata      (timer_rdata),
        .timer_tick (timer_tick)
    );

    always_comb begin
        events            = '0;
        events[IRQ_GPIO]  = gpio_event;
        events[IRQ_TIMER] = timer_tick;
    end

    periph_irq_ctrl #(.base_addr(irq_base)) irq_inst (
        .clk     (clk),
        .reset   (reset),
        .bus_req (bus_req),
        .rdata   (irq_rdata),
        .events  (events),
        .irq     (irq)
    );

    // each block returns zero outside its own window.
    assign rdata = gpio_rdata | timer_rdata | irq_rdata;

endmodule

//--- verilog/periph_irq_ctrl.sv
/*
 * Interrupt controller. Latches source events into pending bits, masks them
 * and drives the single interrupt line; pending bits are write-1-to-clear.
 */
module periph_irq_ctrl
    import periph_pkg::*;
#(
    parameter addr_t base_addr = IRQ_BASE_DEFAULT
) (
    input  logic     clk,
    input  logic     reset,
    input  bus_req_t bus_req,
    output byte_t    rdata,
    input  irq_vec_t events,
    output logic     irq
);

    addr_t    offset;
    logic     sel;
    irq_vec_t pending;
    irq_vec_t clear;
    byte_t    mask;
    byte_t    mask_rdata;
    byte_t    pending_rdata;

    assign offset = bus_req.addr - base_addr;
    assign sel    = bus_req.enable && (offset < IRQ_SPAN);

    periph_reg_rw #(.reg_addr(MASK), .reset_value(8'h00)) mask_reg (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .local_sel (sel),
        .rdata     (mask_rdata),
        .data      (mask)
    );

    assign clear = (sel && bus_req.write_en && offset[2:0] == PENDING)
                 ? irq_vec_t'(bus_req.data) : '0;

    assign pending_rdata = (sel && !bus_req.write_en && offset[2:0] == PENDING)
                         ? byte_t'(pending) : '0;

    assign rdata = pending_rdata | mask_rdata;

    // an event in the same cycle as its clear keeps the bit set.
    always_ff @(posedge clk) begin
        if (!reset) begin
            pending <= '0;
            irq     <= 1'b0;
        end else begin
            pending <= (pending & ~clear) | events;
            irq     <= |(pending & irq_vec_t'(mask));
        end
    end

endmodule

//--- verilog/periph_timer.sv
/*
 * Interval timer. The count runs while the run bit is set and wraps to zero
 * after reaching the compare value, pulsing timer_tick on each wrap.
 */
module periph_timer
    import periph_pkg::*;
#(
    parameter addr_t base_addr = TIMER_BASE_DEFAULT
) (
    input  logic     clk,
    input  logic     reset,
    input  bus_req_t bus_req,
    output byte_t    rdata,
    output logic     timer_tick
);

    addr_t  offset;
    logic   sel;
    byte_t  ctrl;
    count_t cmp;
    count_t count;
    byte_t  ctrl_rdata;
    byte_t  cmp_lo_rdata;
    byte_t  cmp_hi_rdata;
    byte_t  cnt_rdata;

    assign offset = bus_req.addr - base_addr;
    assign sel    = bus_req.enable && (offset < TIMER_SPAN);

    periph_reg_rw #(.reg_addr(CTRL), .reset_value(8'h00)) ctrl_reg (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .local_sel (sel),
        .rdata     (ctrl_rdata),
        .data      (ctrl)
    );

    periph_reg_rw #(.reg_addr(CMP_LO), .reset_value(8'h00)) cmp_lo_reg (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .local_sel (sel),
        .rdata     (cmp_lo_rdata),
        .data      (cmp[7:0])
    );

    periph_reg_rw #(.reg_addr(CMP_HI), .reset_value(8'h00)) cmp_hi_reg (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .local_sel (sel),
        .rdata     (cmp_hi_rdata),
        .data      (cmp[15:8])
    );

    // the count offsets are read only, writes there fall on nothing.
    always_comb begin
        cnt_rdata = '0;
        if (sel && !bus_req.write_en) begin
            if (offset[2:0] == CNT_LO) begin
                cnt_rdata = count[7:0];
            end else if (offset[2:0] == CNT_HI) begin
                cnt_rdata = count[15:8];
            end
        end
    end

    assign rdata = ctrl_rdata | cmp_lo_rdata | cmp_hi_rdata | cnt_rdata;

    // with compare value C a tick comes every C+1 cycles.
    always_ff @(posedge clk) begin
        if (!reset) begin
            count      <= '0;
            timer_tick <= 1'b0;
        end else begin
            timer_tick <= 1'b0;
            if (ctrl[0]) begin
                if (count == cmp) begin
                    count      <= '0;
                    timer_tick <= 1'b1;
                end else begin
                    count <= count + count_t'(1);
                end
            end
        end
    end

endmodule

//--- verilog/periph_gpio.sv
/*
 * GPIO block with 16 outputs, 16 inputs and per-pin rising and falling
 * edge masks that raise a one-cycle event towards the interrupt controller.
 */
module periph_gpio
    import periph_pkg::*;
#(
    parameter addr_t base_addr = GPIO_BASE_DEFAULT
) (
    input  logic     clk,
    input  logic     reset,
    input  bus_req_t bus_req,
    output byte_t    rdata,
    input  pins_t    gpi,
    output pins_t    gpo,
    output logic     gpio_event
);

    addr_t offset;
    logic  sel;
    pins_t rise_mask;
    pins_t fall_mask;
    pins_t gpi_q;
    pins_t gpi_prev;
    pins_t rise;
    pins_t fall;
    byte_t gpi_rdata;
    byte_t gpo_lo_rdata;
    byte_t gpo_hi_rdata;
    byte_t rise_lo_rdata;
    byte_t rise_hi_rdata;
    byte_t fall_lo_rdata;
    byte_t fall_hi_rdata;

    // addresses below the base wrap to a large offset and miss the window.
    assign offset = bus_req.addr - base_addr;
    assign sel    = bus_req.enable && (offset < GPIO_SPAN);

    periph_reg_rw #(.reg_addr(GPO_LO), .reset_value(8'h00)) gpo_lo_reg (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .local_sel (sel),
        .rdata     (gpo_lo_rdata),
        .data      (gpo[7:0])
    );

    periph_reg_rw #(.reg_addr(GPO_HI), .reset_value(8'h00)) gpo_hi_reg (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .local_sel (sel),
        .rdata     (gpo_hi_rdata),
        .data      (gpo[15:8])
    );

    periph_reg_rw #(.reg_addr(RISE_LO), .reset_value(8'h00)) rise_lo_reg (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .local_sel (sel),
        .rdata     (rise_lo_rdata),
        .data      (rise_mask[7:0])
    );

    periph_reg_rw #(.reg_addr(RISE_HI), .reset_value(8'h00)) rise_hi_reg (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .local_sel (sel),
        .rdata     (rise_hi_rdata),
        .data      (rise_mask[15:8])
    );

    periph_reg_rw #(.reg_addr(FALL_LO), .reset_value(8'h00)) fall_lo_reg (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .local_sel (sel),
        .rdata     (fall_lo_rdata),
        .data      (fall_mask[7:0])
    );

    periph_reg_rw #(.reg_addr(FALL_HI), .reset_value(8'h00)) fall_hi_reg (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .local_sel (sel),
        .rdata     (fall_hi_rdata),
        .data      (fall_mask[15:8])
    );

    // the input pins are read straight through, they have no register.
    always_comb begin
        gpi_rdata = '0;
        if (sel && !bus_req.write_en) begin
            if (offset[2:0] == GPI_LO) begin
                gpi_rdata = gpi[7:0];
            end else if (offset[2:0] == GPI_HI) begin
                gpi_rdata = gpi[15:8];
            end
        end
    end

    assign rdata = gpo_lo_rdata | gpo_hi_rdata | gpi_rdata
                 | rise_lo_rdata | rise_hi_rdata | fall_lo_rdata | fall_hi_rdata;

    // edges are taken between the sampled pin state and the one before it.
    assign rise = gpi_q & ~gpi_prev;
    assign fall = ~gpi_q & gpi_prev;

    always_ff @(posedge clk) begin
        if (!reset) begin
            gpi_q      <= '0;
            gpi_prev   <= '0;
            gpio_event <= 1'b0;
        end else begin
            gpi_q      <= gpi;
            gpi_prev   <= gpi_q;
            gpio_event <= |(rise & rise_mask) | |(fall & fall_mask);
        end
    end

endmodule

//--- verilog/periph_reg_rw.sv
/*
 * One byte-wide read/write control register on the system bus.
 * The owning block decodes its window, the register matches its own offset.
 */
module periph_reg_rw
    import periph_pkg::*;
#(
    parameter offset_t reg_addr    = 3'd0,
    parameter byte_t   reset_value = 8'h00
) (
    input  logic     clk,
    input  logic     reset,
    input  bus_req_t bus_req,
    input  logic     local_sel,
    output byte_t    rdata,
    output byte_t    data
);

    byte_t value;
    logic  hit;

    // windows start on a multiple of 8, so the low address bits are the offset.
    assign hit = local_sel && (bus_req.addr[2:0] == reg_addr);

    always_ff @(posedge clk) begin
        if (!reset) begin
            value <= reset_value;
        end else if (hit && bus_req.write_en) begin
            value <= bus_req.data;
        end
    end

    // read data is only driven during a read of this offset.
    assign rdata = (hit && !bus_req.write_en) ? value : '0;
    assign data  = value;

endmodule

//--- verilog/periph_pkg.sv
/*
 * Peripheral subsystem definitions: system bus types, register offsets,
 * interrupt source numbering and default base addresses.
 */
package periph_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;
    typedef logic [15:0] pins_t;
    typedef logic [15:0] count_t;
    typedef logic [1:0]  irq_vec_t;
    typedef logic [2:0]  offset_t;

    // one access on the system bus, 26 bits in total.
    typedef struct packed {
        logic  enable;
        logic  write_en;
        addr_t addr;
        byte_t data;
    } bus_req_t;

    // interrupt source numbers, as bit positions in irq_vec_t.
    localparam int IRQ_GPIO  = 0;
    localparam int IRQ_TIMER = 1;

    localparam offset_t GPO_LO  = 3'd0;
    localparam offset_t GPO_HI  = 3'd1;
    localparam offset_t GPI_LO  = 3'd2;
    localparam offset_t GPI_HI  = 3'd3;
    localparam offset_t RISE_LO = 3'd4;
    localparam offset_t RISE_HI = 3'd5;
    localparam offset_t FALL_LO = 3'd6;
    localparam offset_t FALL_HI = 3'd7;

    // bit 0 of CTRL is the run bit.
    localparam offset_t CTRL   = 3'd0;
    localparam offset_t CMP_LO = 3'd1;
    localparam offset_t CMP_HI = 3'd2;
    localparam offset_t CNT_LO = 3'd3;
    localparam offset_t CNT_HI = 3'd4;

    localparam offset_t PENDING = 3'd0;
    localparam offset_t MASK    = 3'd1;

    // window sizes; every base address is aligned to 8.
    localparam addr_t GPIO_SPAN  = 16'd8;
    localparam addr_t TIMER_SPAN = 16'd5;
    localparam addr_t IRQ_SPAN   = 16'd2;

    localparam addr_t GPIO_BASE_DEFAULT  = 16'hFF00;
    localparam addr_t TIMER_BASE_DEFAULT = 16'hFF08;
    localparam addr_t IRQ_BASE_DEFAULT   = 16'hFF10;

endpackage
